/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Data and address width.
`define MEM_XLEN 32

`define MEM_REG_BITS 5   // Register index width.

// Data memory size in words, as log2.
`define MEM_DEPTH_LOG2 8

// Wait states before ready.
`define MEM_WAIT 2

`endif

/* common/mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

  // One-hot load/store kind.
  typedef struct packed {
    logic lb;
    logic lbu;
    logic lh;
    logic lhu;
    logic lw;
    logic sb;
    logic sh;
    logic sw;
  } lsu_op_t;

  // Execute result entering the memory stage.
  typedef struct packed {
    logic                     valid;
    logic                     wren;
    logic [`MEM_REG_BITS-1:0] waddr;
    logic [`MEM_XLEN-1:0]     wdata;   // ALU result.
    logic [`MEM_XLEN-1:0]     address;
    logic [`MEM_XLEN-1:0]     sdata;
    logic                     load;
    logic                     store;
    lsu_op_t                  lsu_op;
  } mem_op_t;

  // Word request to data memory.
  typedef struct packed {
    logic                     valid;
    logic [`MEM_XLEN-1:0]     addr;
    logic [`MEM_XLEN-1:0]     wdata;
    logic [`MEM_XLEN/8-1:0]   wstrb;   // Zero for reads.
  } mem_req_t;

  typedef struct packed {
    logic                     ready;
    logic [`MEM_XLEN-1:0]     rdata;
  } mem_rsp_t;

  // Bypass to execute.
  typedef struct packed {
    logic                     wren;
    logic [`MEM_REG_BITS-1:0] waddr;
    logic [`MEM_XLEN-1:0]     wdata;
  } fwd_t;

  // Registered writeback record.
  typedef struct packed {
    logic                     valid;
    logic                     wren;
    logic [`MEM_REG_BITS-1:0] waddr;
    logic [`MEM_XLEN-1:0]     wdata;
  } wb_t;

endpackage

/* hdl/store_format.sv */
`timescale 1ns/1ps

module store_format (
  input  mem_pkg::mem_op_t  op,
  input  logic              clear,
  output mem_pkg::mem_req_t req
);

  logic half;
  logic word;

  assign half = op.lsu_op.lh | op.lsu_op.lhu | op.lsu_op.sh;
  assign word = op.lsu_op.lw | op.lsu_op.sw;

  always_comb begin
    req.valid = op.valid & (op.load | op.store) & ~clear;
    req.addr = op.address;

    // Replicate into every lane, strobes pick the one written.
    if (op.lsu_op.sb) begin
      req.wdata = {4{op.sdata[7:0]}};
    end else if (op.lsu_op.sh) begin
      req.wdata = {2{op.sdata[15:0]}};
    end else begin
      req.wdata = op.sdata;
    end

    if (!op.store) begin
      req.wstrb = 4'b0000;   // Read.
    end else if (op.lsu_op.sb) begin
      req.wstrb = 4'b0001 << op.address[1:0];
    end else if (op.lsu_op.sh) begin
      req.wstrb = op.address[1] ? 4'b1100 : 4'b0011;
    end else begin
      req.wstrb = 4'b1111;
    end
  end

  // Issuer must present natural alignment.
  always_comb begin
    if (req.valid) begin
      assert final (!half || !op.address[0])
        else $error("Misaligned half access at %h.", op.address);
      assert final (!word || op.address[1:0] == 2'b00)
        else $error("Misaligned word access at %h.", op.address);
    end
  end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps

module load_align (
  input  logic [31:0]      rdata,
  input  logic [1:0]       offset,
  input  mem_pkg::lsu_op_t lsu_op,
  output logic [31:0]      result
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Lane select by low address bits.
  always_comb begin
    case (offset)
      2'd0: byte_sel = rdata[7:0];
      2'd1: byte_sel = rdata[15:8];
      2'd2: byte_sel = rdata[23:16];
      default: byte_sel = rdata[31:24];
    endcase
    half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
  end

  always_comb begin
    if (lsu_op.lb) begin
      result = {{24{byte_sel[7]}}, byte_sel};
    end else if (lsu_op.lbu) begin
      result = {24'h000000, byte_sel};
    end else if (lsu_op.lh) begin
      result = {{16{half_sel[15]}}, half_sel};
    end else if (lsu_op.lhu) begin
      result = {16'h0000, half_sel};
    end else begin
      result = rdata;   // lw, and don't care for stores.
    end
  end

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_memory (
  input  logic              clock,
  input  logic              reset,
  input  mem_pkg::mem_req_t req,
  output mem_pkg::mem_rsp_t rsp
);

  localparam int DEPTH    = 1 << `MEM_DEPTH_LOG2;
  localparam int CNT_BITS = $clog2(`MEM_WAIT + 2);

  logic [`MEM_XLEN-1:0]       mem [DEPTH] = '{default: '0};
  logic [CNT_BITS-1:0]        wait_cnt;
  logic [`MEM_DEPTH_LOG2-1:0] index;

  assign index = req.addr[`MEM_DEPTH_LOG2+1:2];   // Word address.

  // One-cycle ready once the wait states have elapsed.
  assign rsp.ready = req.valid && (wait_cnt == CNT_BITS'(`MEM_WAIT));
  assign rsp.rdata = mem[index];

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (!req.valid || rsp.ready) begin
      wait_cnt <= '0;   // Next access restarts the count.
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (rsp.ready) begin
      for (int b = 0; b < `MEM_XLEN / 8; b++) begin
        if (req.wstrb[b]) begin
          mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // A pending request is held by the stage until answered or flushed.
  a_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    req.valid && !rsp.ready |=> !req.valid || $stable(req)
  ) else $error("Request changed while pending.");

endmodule

/* memory_stage/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic              clock,
  input  logic              reset,
  input  mem_pkg::mem_op_t  op,
  input  logic              clear,
  input  mem_pkg::mem_rsp_t rsp,
  input  logic [31:0]       ldata,
  output logic              stall,
  output mem_pkg::fwd_t     fwd,
  output mem_pkg::wb_t      wb
);
  import mem_pkg::*;

  wb_t  r;
  wb_t  v;
  logic mem_access;

  always_comb begin
    mem_access = op.valid & (op.load | op.store);

    // Wait on memory, unless the op is being flushed.
    stall = mem_access & ~rsp.ready & ~clear;

    v.valid = op.valid;
    v.wren = op.valid & op.wren;
    v.waddr = op.waddr;
    v.wdata = op.load ? ldata : op.wdata;   // Load result replaces ALU value.

    if (stall | clear) begin
      v.valid = 1'b0;
      v.wren = 1'b0;
    end
  end

  // Forward the value about to be registered.
  always_comb begin
    fwd.wren = v.wren;
    fwd.waddr = v.waddr;
    fwd.wdata = v.wdata;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r.valid <= 1'b0;
      r.wren <= 1'b0;
    end else begin
      r.valid <= v.valid;
      r.wren <= v.wren;
    end
    r.waddr <= v.waddr;
    r.wdata <= v.wdata;
  end

  assign wb = r;

  // The issuer holds the op in place while stalled.
  a_op_held: assert property (
    @(posedge clock) disable iff (reset)
    stall |=> $stable(op)
  ) else $error("Op changed while the stage was stalled.");

endmodule

/* hdl/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic             clock,
  input  logic             reset,
  input  mem_pkg::mem_op_t op,
  input  logic             clear,
  output logic             stall,
  output mem_pkg::fwd_t    fwd,
  output mem_pkg::wb_t     wb
);
  import mem_pkg::*;

  mem_req_t    req;
  mem_rsp_t    rsp;
  logic [31:0] ldata;

  store_format u_store_format (
    .op    (op),
    .clear (clear),
    .req   (req)
  );

  data_memory u_data_memory (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  load_align u_load_align (
    .rdata  (rsp.rdata),
    .offset (op.address[1:0]),
    .lsu_op (op.lsu_op),
    .result (ldata)
  );

  memory_stage u_memory_stage (
    .clock (clock),
    .reset (reset),
    .op    (op),
    .clear (clear),
    .rsp   (rsp),
    .ldata (ldata),
    .stall (stall),
    .fwd   (fwd),
    .wb    (wb)
  );

endmodule

/* test/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int byte_bits = `MEM_DEPTH_LOG2 + 2;
  localparam int ref_bytes = 1 << byte_bits;
  localparam int directed_ops = 21;
  localparam int random_ops = 200;
  localparam int watchdog_cycles = (directed_ops + random_ops) * (`MEM_WAIT + 3) + 50;
  localparam logic [31:0] low_window = 32'h0000_0100;
  localparam logic [31:0] high_window = 32'(ref_bytes - 64);   // Top 16 words.

  // Op kinds used by the stimulus.
  localparam int op_alu = 0;
  localparam int op_lb = 1;
  localparam int op_lbu = 2;
  localparam int op_lh = 3;
  localparam int op_lhu = 4;
  localparam int op_lw = 5;
  localparam int op_sb = 6;
  localparam int op_sh = 7;
  localparam int op_sw = 8;

  logic    clock;
  logic    reset;
  mem_op_t op;
  logic    clear;
  logic    stall;
  fwd_t    fwd;
  wb_t     wb;

  logic [7:0]  ref_mem [0:ref_bytes-1] = '{default: 8'h00};
  logic [31:0] lfsr_state = 32'd79118;
  logic [31:0] exp_result;   // Value the op on the inputs should produce.
  wb_t         exp_wb;
  int          stall_cycles;
  logic        exp_stall;
  logic        exp_accept;
  logic        exp_fwd_wren;

  mem_subsystem_top dut (
    .clock (clock),
    .reset (reset),
    .op    (op),
    .clear (clear),
    .stall (stall),
    .fwd   (fwd),
    .wb    (wb)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  function automatic mem_op_t make_op(input int kind, input logic [31:0] address,
                                      input logic [31:0] sdata,
                                      input logic [`MEM_REG_BITS-1:0] waddr,
                                      input logic [31:0] wdata, input logic wren);
    mem_op_t m;
    m = '0;
    m.valid = 1'b1;
    m.wren = wren;
    m.waddr = waddr;
    m.wdata = wdata;
    m.address = address;
    m.sdata = sdata;
    case (kind)
      op_lb:   m.lsu_op.lb = 1'b1;
      op_lbu:  m.lsu_op.lbu = 1'b1;
      op_lh:   m.lsu_op.lh = 1'b1;
      op_lhu:  m.lsu_op.lhu = 1'b1;
      op_lw:   m.lsu_op.lw = 1'b1;
      op_sb:   m.lsu_op.sb = 1'b1;
      op_sh:   m.lsu_op.sh = 1'b1;
      op_sw:   m.lsu_op.sw = 1'b1;
      default: m.lsu_op = '0;   // ALU op.
    endcase
    m.load = (kind >= op_lb && kind <= op_lw);
    m.store = (kind >= op_sb);
    return m;
  endfunction

  // Little-endian read of the reference bytes, then extension.
  function automatic logic [31:0] expected_result(input mem_op_t m);
    logic [byte_bits-3:0] word;
    logic [7:0]           lane;
    logic [15:0]          half;
    logic [31:0]          full;
    word = m.address[byte_bits-1:2];
    lane = ref_mem[m.address[byte_bits-1:0]];
    half = {ref_mem[{word, m.address[1], 1'b1}], ref_mem[{word, m.address[1], 1'b0}]};
    full = {ref_mem[{word, 2'd3}], ref_mem[{word, 2'd2}],
            ref_mem[{word, 2'd1}], ref_mem[{word, 2'd0}]};
    if (!m.load) begin
      return m.wdata;
    end else if (m.lsu_op.lb) begin
      return {{24{lane[7]}}, lane};
    end else if (m.lsu_op.lbu) begin
      return {24'h000000, lane};
    end else if (m.lsu_op.lh) begin
      return {{16{half[15]}}, half};
    end else if (m.lsu_op.lhu) begin
      return {16'h0000, half};
    end
    return full;
  endfunction

  task automatic commit_store(input mem_op_t m);
    logic [byte_bits-1:0] a;
    logic [byte_bits-3:0] word;
    a = m.address[byte_bits-1:0];
    word = a[byte_bits-1:2];
    if (m.lsu_op.sb) begin
      ref_mem[a] = m.sdata[7:0];
    end else if (m.lsu_op.sh) begin
      ref_mem[{word, a[1], 1'b0}] = m.sdata[7:0];
      ref_mem[{word, a[1], 1'b1}] = m.sdata[15:8];
    end else begin
      for (int b = 0; b < 4; b++) begin
        ref_mem[{word, 2'(b)}] = m.sdata[8*b +: 8];
      end
    end
  endtask

  // Reference model of the stage, one step per clock.
  assign exp_stall = op.valid && (op.load || op.store) && !clear &&
                     (stall_cycles < `MEM_WAIT);
  assign exp_accept = op.valid && !exp_stall;
  assign exp_fwd_wren = exp_accept && !clear && op.wren;

  always @(posedge clock) begin
    if (reset) begin
      exp_wb <= '0;
      stall_cycles <= 0;
    end else begin
      stall_cycles <= exp_stall ? stall_cycles + 1 : 0;
      exp_wb.valid <= exp_accept && !clear;
      exp_wb.wren <= exp_fwd_wren;
      exp_wb.waddr <= op.waddr;
      exp_wb.wdata <= exp_result;
      if (exp_accept && !clear && op.store) begin
        commit_store(op);
      end
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on first error.");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    fail_run($sformatf("** Error at %0t: %s expected 0x%h, actual 0x%h",
                       $time, name, expected, actual));
  endtask

  a_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
    else report_mismatch("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));

  a_fwd_wren: assert property (@(posedge clock) disable iff (reset) fwd.wren == exp_fwd_wren)
    else report_mismatch("fwd.wren", 32'($sampled(exp_fwd_wren)), 32'($sampled(fwd.wren)));

  a_fwd_waddr: assert property (
    @(posedge clock) disable iff (reset) fwd.wren |-> fwd.waddr == op.waddr
  ) else report_mismatch("fwd.waddr", 32'($sampled(op.waddr)), 32'($sampled(fwd.waddr)));

  a_fwd_wdata: assert property (
    @(posedge clock) disable iff (reset) fwd.wren |-> fwd.wdata == exp_result
  ) else report_mismatch("fwd.wdata", $sampled(exp_result), $sampled(fwd.wdata));

  a_wb_valid: assert property (@(posedge clock) disable iff (reset) wb.valid == exp_wb.valid)
    else report_mismatch("wb.valid", 32'($sampled(exp_wb.valid)), 32'($sampled(wb.valid)));

  a_wb_wren: assert property (@(posedge clock) disable iff (reset) wb.wren == exp_wb.wren)
    else report_mismatch("wb.wren", 32'($sampled(exp_wb.wren)), 32'($sampled(wb.wren)));

  a_wb_waddr: assert property (
    @(posedge clock) disable iff (reset) wb.valid |-> wb.waddr == exp_wb.waddr
  ) else report_mismatch("wb.waddr", 32'($sampled(exp_wb.waddr)), 32'($sampled(wb.waddr)));

  a_wb_wdata: assert property (
    @(posedge clock) disable iff (reset) wb.valid |-> wb.wdata == exp_wb.wdata
  ) else report_mismatch("wb.wdata", $sampled(exp_wb.wdata), $sampled(wb.wdata));

  // Holds the op on the inputs until the stage takes it.
  task automatic issue_op(input mem_op_t next, input logic next_clear);
    logic held;
    op = next;
    clear = next_clear;
    exp_result = expected_result(next);
    held = 1'b1;
    while (held) begin
      @(negedge clock);
      held = stall;
      @(posedge clock);
      #1;
    end
  endtask

  task automatic random_op(output mem_op_t m, output logic clr);
    logic [31:0]              r;
    logic [31:0]              addr;
    logic [31:0]              sdata;
    logic [31:0]              wdata;
    logic [`MEM_REG_BITS-1:0] waddr;
    logic                     wren;
    int                       kind;
    r = random_bits(4);
    if (r < 4) begin
      kind = op_alu;
    end else begin
      kind = int'((r - 4) % 8) + op_lb;
    end
    r = random_bits(1);
    addr = r[0] ? high_window : low_window;
    r = random_bits(6);
    addr = addr | {26'd0, r[5:0]};
    if (kind == op_lh || kind == op_lhu || kind == op_sh) begin
      addr[0] = 1'b0;
    end
    if (kind == op_lw || kind == op_sw) begin
      addr[1:0] = 2'b00;
    end
    r = random_bits(`MEM_REG_BITS);
    waddr = r[`MEM_REG_BITS-1:0];
    r = random_bits(1);
    wren = r[0];
    sdata = random_bits(32);
    wdata = random_bits(32);
    r = random_bits(4);
    clr = (r == 0);   // About one op in sixteen.
    m = make_op(kind, addr, sdata, waddr, wdata, wren);
  endtask

  initial begin
    #(watchdog_cycles * 10);
    fail_run("Watchdog expired: the ops did not complete in time.");
  end

  initial begin
    mem_op_t next;
    logic    next_clear;
    op = '0;
    clear = 1'b0;
    exp_result = '0;
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    issue_op(make_op(op_alu, 32'h0, 32'h0, 5'd5, 32'h1234_5678, 1'b1), 1'b0);
    issue_op(make_op(op_alu, 32'h0, 32'h0, 5'd9, 32'hDEAD_BEEF, 1'b0), 1'b0);
    issue_op(make_op(op_sw, 32'h40, 32'h80FF_7F01, 5'd0, 32'h40, 1'b0), 1'b0);
    for (int off = 0; off < 4; off++) begin
      issue_op(make_op(op_lb, 32'h40 + off, 32'h0, 5'd1, 32'h0, 1'b1), 1'b0);
      issue_op(make_op(op_lbu, 32'h40 + off, 32'h0, 5'd2, 32'h0, 1'b1), 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_op(make_op(op_lh, 32'h40 + off, 32'h0, 5'd3, 32'h0, 1'b1), 1'b0);
      issue_op(make_op(op_lhu, 32'h40 + off, 32'h0, 5'd4, 32'h0, 1'b1), 1'b0);
    end
    issue_op(make_op(op_lw, 32'h40, 32'h0, 5'd6, 32'h0, 1'b1), 1'b0);
    issue_op(make_op(op_sb, 32'h41, 32'h0000_00A5, 5'd0, 32'h41, 1'b0), 1'b0);
    issue_op(make_op(op_sh, 32'h42, 32'h0000_9876, 5'd0, 32'h42, 1'b0), 1'b0);
    issue_op(make_op(op_lw, 32'h40, 32'h0, 5'd7, 32'h0, 1'b1), 1'b0);
    // Flushed store leaves the word unchanged.
    issue_op(make_op(op_sw, 32'h40, 32'hFFFF_FFFF, 5'd0, 32'h40, 1'b0), 1'b1);
    issue_op(make_op(op_lw, 32'h40, 32'h0, 5'd0, 32'h0, 1'b1), 1'b0);   // x0 target.

    for (int i = 0; i < random_ops; i++) begin
      random_op(next, next_clear);
      issue_op(next, next_clear);
    end

    op = '0;
    clear = 1'b0;
    repeat (3) @(posedge clock);
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/mem_pkg.sv
hdl/store_format.sv
hdl/load_align.sv
hdl/data_memory.sv
memory_stage/memory_stage.sv
hdl/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := common/mem_consts.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
